// ==== pmpPkg.sv ====
// PMP gate shared definitions
// Widths, privilege and access encodings, and the request, response and config records

package pmpPkg;

  // Physical address width and the width of one PMP address register
  localparam int PaBits = 34;
  localparam int XLen = 32;
  localparam int TagBits = 4;
  localparam int IdxBits = 4;

  // Privilege levels follow the RISC-V encoding, value 2 is reserved
  typedef enum logic [1:0] {
    UMode = 2'd0,
    SMode = 2'd1,
    MMode = 2'd3
  } privModeT;

  typedef enum logic [1:0] {
    Fetch = 2'd0,
    Load  = 2'd1,
    Store = 2'd2
  } accessKindT;

  // Address matching mode held in the A field of a config byte
  typedef enum logic [1:0] {
    Off   = 2'd0,
    Tor   = 2'd1,
    Na4   = 2'd2,
    Napot = 2'd3
  } pmpModeT;

  // Config byte laid out as L, two reserved bits, A, X, W, R
  typedef struct packed {
    logic    lock;
    logic [1:0] rsvd;
    pmpModeT mode;
    logic    x;
    logic    w;
    logic    r;
  } pmpCfgT;

  typedef struct packed {
    logic [PaBits-1:0]  addr;
    accessKindT         kind;
    privModeT           priv;
    logic [TagBits-1:0] tag;
  } accessReqT;

  typedef struct packed {
    logic [TagBits-1:0] tag;
    accessKindT         kind;
    logic               fault;
  } accessRespT;

  // One config port write, the two enables act independently
  typedef struct packed {
    logic               cfgEn;
    logic               adrEn;
    logic [IdxBits-1:0] idx;
    pmpCfgT             cfg;
    logic [XLen-1:0]    adr;
  } cfgWriteT;

endpackage

// ==== pmpAdrDec.sv ====
// PMP single-entry address decoder
// Matches one entry against an address and extends the lowest-match priority chain
`timescale 1ns/10ps

module pmpAdrDec import pmpPkg::*; (
  input  logic [PaBits-1:0] addr,
  input  pmpCfgT            cfg,
  input  logic [XLen-1:0]   adr,
  input  logic [XLen-1:0]   prevAdr,
  input  logic              noLowerMatchIn,
  output logic              match,
  output logic              noLowerMatchOut,
  output logic              active,
  output logic              lockHit,
  output logic              readHit,
  output logic              writeHit,
  output logic              execHit
);

  logic [XLen-1:0] wordAdr;
  logic [XLen-1:0] adrPlusOne;
  logic [XLen-1:0] napotMask;
  logic            torMatch;
  logic            na4Match;
  logic            napotMatch;
  logic            selected;

  // PMP address registers count in 4-byte words
  assign wordAdr = addr[PaBits-1:2];

  // Top of range is exclusive and the base comes from the entry below
  assign torMatch = (prevAdr <= wordAdr) && (wordAdr < adr);

  assign na4Match = (wordAdr == adr);

  // The trailing ones plus the first zero above them are don't-care bits
  // An all-ones address therefore covers the whole space
  assign adrPlusOne = adr + 1'b1;
  assign napotMask = adr ^ adrPlusOne;
  assign napotMatch = ((wordAdr ^ adr) & ~napotMask) == '0;

  always_comb begin
    unique case (cfg.mode)
      Tor:     match = torMatch;
      Na4:     match = na4Match;
      Napot:   match = napotMatch;
      default: match = 1'b0;
    endcase
  end

  assign active = (cfg.mode != Off);

  //////////////////////////////
  // Priority chain
  //////////////////////////////

  // Only the lowest matching entry gets to report its flags
  assign selected = match && noLowerMatchIn;
  assign noLowerMatchOut = noLowerMatchIn && !match;

  assign lockHit = selected && cfg.lock;
  assign readHit = selected && cfg.r;
  assign writeHit = selected && cfg.w;
  assign execHit = selected && cfg.x;

endmodule

// ==== pmpRegFile.sv ====
// PMP register file
// Holds the config bytes and address words and enforces the lock rules on writes
`timescale 1ns/10ps

module pmpRegFile import pmpPkg::*; #(
  parameter int NumEntries = 8
) (
  input  logic            clk,
  input  logic            rstN,
  input  cfgWriteT        cfgWrite,
  output pmpCfgT          pmpCfg [NumEntries],
  output logic [XLen-1:0] pmpAdr [NumEntries]
);

  logic   entryLocked;
  logic   nextTorLocked;
  pmpCfgT cfgClean;

  // Look up the lock state of the target entry and of the one above it
  // Indexes outside the bank find nothing and the write falls through
  always_comb begin
    entryLocked = 1'b0;
    nextTorLocked = 1'b0;
    for (int i = 0; i < NumEntries; i++) begin
      if (cfgWrite.idx == i) begin
        entryLocked = pmpCfg[i].lock;
      end
      // A locked TOR entry also freezes the base address below it
      if (cfgWrite.idx + 1 == i) begin
        nextTorLocked = pmpCfg[i].lock && (pmpCfg[i].mode == Tor);
      end
    end
  end

  // Reserved bits always read back as zero
  always_comb begin
    cfgClean = cfgWrite.cfg;
    cfgClean.rsvd = 2'b00;
  end

  //////////////////////////////
  // Entry storage
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      // All entries come up Off and unlocked
      for (int i = 0; i < NumEntries; i++) begin
        pmpCfg[i] <= '0;
        pmpAdr[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NumEntries; i++) begin
        if (cfgWrite.idx == i) begin
          if (cfgWrite.cfgEn && !entryLocked) begin
            pmpCfg[i] <= cfgClean;
          end
          if (cfgWrite.adrEn && !entryLocked && !nextTorLocked) begin
            pmpAdr[i] <= cfgWrite.adr;
          end
        end
      end
    end
  end

  // Once locked an entry stays frozen until the next reset
  for (genvar i = 0; i < NumEntries; i++) begin : gLockCheck
    assert property (@(posedge clk) disable iff (!rstN)
      pmpCfg[i].lock |=> $stable(pmpCfg[i]) && $stable(pmpAdr[i]));
  end

endmodule

// ==== pmpChecker.sv ====
// PMP checker
// Runs all entry decoders on one access and decides whether it faults
`timescale 1ns/10ps

module pmpChecker import pmpPkg::*; #(
  parameter int NumEntries = 8
) (
  input  accessReqT       req,
  input  pmpCfgT          pmpCfg [NumEntries],
  input  logic [XLen-1:0] pmpAdr [NumEntries],
  output logic            fault
);

  logic [XLen-1:0]       prevAdr [NumEntries];
  logic [NumEntries:0]   noLowerMatch;
  logic [NumEntries-1:0] activeVec;
  logic [NumEntries-1:0] lockVec;
  logic [NumEntries-1:0] readVec;
  logic [NumEntries-1:0] writeVec;
  logic [NumEntries-1:0] execVec;
  logic                  enforce;
  logic                  granted;

  // Nothing sits below entry 0 so the chain starts open
  assign noLowerMatch[0] = 1'b1;

  for (genvar i = 0; i < NumEntries; i++) begin : gEntry
    // TOR base is the address register of the previous entry, zero for entry 0
    if (i == 0) begin : gFirst
      assign prevAdr[i] = '0;
    end else begin : gNext
      assign prevAdr[i] = pmpAdr[i-1];
    end

    pmpAdrDec i_dec (
      .addr            (req.addr),
      .cfg             (pmpCfg[i]),
      .adr             (pmpAdr[i]),
      .prevAdr         (prevAdr[i]),
      .noLowerMatchIn  (noLowerMatch[i]),
      .match           (),
      .noLowerMatchOut (noLowerMatch[i+1]),
      .active          (activeVec[i]),
      .lockHit         (lockVec[i]),
      .readHit         (readVec[i]),
      .writeHit        (writeVec[i]),
      .execHit         (execVec[i])
    );
  end

  // Machine mode only obeys a locked entry, lower modes obey any active bank
  assign enforce = (req.priv == MMode) ? |lockVec : |activeVec;

  always_comb begin
    unique case (req.kind)
      Fetch:   granted = |execVec;
      Load:    granted = |readVec;
      Store:   granted = |writeVec;
      default: granted = 1'b0;
    endcase
  end

  // The chain falls out the top when no entry matched, and a miss grants nothing
  assign fault = enforce && (noLowerMatch[NumEntries] || !granted);

endmodule

// ==== accessQueue.sv ====
// Access request queue
// Circular FIFO sized to the credit pool, fed by the requester and drained by the gate
`timescale 1ns/10ps

module accessQueue import pmpPkg::*; #(
  parameter int QueueDepth = 4
) (
  input  logic      clk,
  input  logic      rstN,
  input  logic      reqValid,
  input  accessReqT reqData,
  input  logic      headPop,
  output logic      headValid,
  output accessReqT headData
);

  localparam int PtrBits = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int CntBits = $clog2(QueueDepth + 1);

  accessReqT          mem [QueueDepth];
  logic [PtrBits-1:0] wrPtr;
  logic [PtrBits-1:0] rdPtr;
  logic [CntBits-1:0] count;

  // Storage carries payload only, validity lives in the count
  always_ff @(posedge clk) begin
    if (reqValid) begin
      mem[wrPtr] <= reqData;
    end
  end

  //////////////////////////////
  // Pointers and occupancy
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (reqValid) begin
        wrPtr <= (wrPtr == PtrBits'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (headPop) begin
        rdPtr <= (rdPtr == PtrBits'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      if (reqValid && !headPop) begin
        count <= count + 1'b1;
      end else if (!reqValid && headPop) begin
        count <= count - 1'b1;
      end
    end
  end

  // Head is valid from the cycle after its push
  assign headValid = (count != '0);
  assign headData = mem[rdPtr];

  // The requester may only push while it holds a credit, so a full queue means misuse
  assert property (@(posedge clk) disable iff (!rstN)
    reqValid |-> count != CntBits'(QueueDepth));

  // The gate must never pop an empty queue
  assert property (@(posedge clk) disable iff (!rstN)
    headPop |-> headValid);

endmodule

// ==== pmpGate.sv ====
// PMP check stage
// Pops the queue head into the response register and hands a credit back per pop
`timescale 1ns/10ps

module pmpGate import pmpPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       headValid,
  input  accessReqT  headData,
  input  logic       fault,
  input  logic       respReady,
  output logic       headPop,
  output accessReqT  checkReq,
  output logic       respValid,
  output accessRespT respData,
  output logic       creditReturn
);

  logic outFree;

  // Checker looks at the head directly and answers in the same cycle
  assign checkReq = headData;

  // Output register takes a new item when empty or draining this cycle
  assign outFree = !respValid || respReady;
  assign headPop = headValid && outFree;

  //////////////////////////////
  // Response register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      respValid <= 1'b0;
      creditReturn <= 1'b0;
    end else begin
      if (headPop) begin
        respValid <= 1'b1;
      end else if (respReady) begin
        respValid <= 1'b0;
      end
      // One credit per freed slot, aligned with the new response
      creditReturn <= headPop;
    end
  end

  always_ff @(posedge clk) begin
    if (headPop) begin
      respData.tag <= headData.tag;
      respData.kind <= headData.kind;
      respData.fault <= fault;
    end
  end

  // A stalled response holds its payload until the receiver takes it
  assert property (@(posedge clk) disable iff (!rstN)
    respValid && !respReady |=> respValid && $stable(respData));

endmodule

// ==== pmpUnit.sv ====
// PMP gate top level
// Ties the register file, request queue, checker and check stage together
`timescale 1ns/10ps

module pmpUnit import pmpPkg::*; #(
  parameter int NumEntries = 8,
  parameter int QueueDepth = 4
) (
  input  logic       clk,
  input  logic       rstN,
  input  cfgWriteT   cfgWrite,
  input  logic       reqValid,
  input  accessReqT  reqData,
  input  logic       respReady,
  output logic       respValid,
  output accessRespT respData,
  output logic       creditReturn
);

  pmpCfgT          pmpCfg [NumEntries];
  logic [XLen-1:0] pmpAdr [NumEntries];
  logic            headValid;
  accessReqT       headData;
  logic            headPop;
  accessReqT       checkReq;
  logic            fault;

  // Entry state changes only through the config port
  pmpRegFile #(
    .NumEntries (NumEntries)
  ) i_regFile (
    .clk      (clk),
    .rstN     (rstN),
    .cfgWrite (cfgWrite),
    .pmpCfg   (pmpCfg),
    .pmpAdr   (pmpAdr)
  );

  accessQueue #(
    .QueueDepth (QueueDepth)
  ) i_queue (
    .clk       (clk),
    .rstN      (rstN),
    .reqValid  (reqValid),
    .reqData   (reqData),
    .headPop   (headPop),
    .headValid (headValid),
    .headData  (headData)
  );

  // Combinational decision on whatever the gate presents
  pmpChecker #(
    .NumEntries (NumEntries)
  ) i_checker (
    .req    (checkReq),
    .pmpCfg (pmpCfg),
    .pmpAdr (pmpAdr),
    .fault  (fault)
  );

  pmpGate i_gate (
    .clk          (clk),
    .rstN         (rstN),
    .headValid    (headValid),
    .headData     (headData),
    .fault        (fault),
    .respReady    (respReady),
    .headPop      (headPop),
    .checkReq     (checkReq),
    .respValid    (respValid),
    .respData     (respData),
    .creditReturn (creditReturn)
  );

endmodule

// ==== tbPmpUnit.sv ====
// PMP gate testbench
// Random credit-based requester, reference PMP model and in-order response checks
`timescale 1ns/10ps

module tbPmpUnit import pmpPkg::*; ();

  localparam int NumEntries = 8;
  localparam int QueueDepth = 4;
  localparam int ResetCycles = 10;
  localparam int NumTests = 6;
  localparam int AccPerTest = 150;
  // Worst case per access with throttled requests and a random ready
  localparam int StallCycles = 8;
  localparam int CfgCycles = 8 * NumEntries;
  localparam int CycleLimit = NumTests * (ResetCycles + CfgCycles + AccPerTest * StallCycles);

  logic       clk;
  logic       rstN;
  cfgWriteT   cfgWrite;
  logic       reqValid;
  accessReqT  reqData;
  logic       respReady;
  logic       respValid;
  accessRespT respData;
  logic       creditReturn;

  // Reference copy of the PMP bank and the requests still in flight
  pmpCfgT          mCfg [NumEntries];
  logic [XLen-1:0] mAdr [NumEntries];
  accessReqT       expQ [$];
  accessReqT       expReq;
  logic [3:0]      nextTag;
  int sentCnt;
  int retCnt;
  int errors;
  int checks;
  int testsRun;
  int testErrBase;
  int cycles;

  pmpUnit #(
    .NumEntries (NumEntries),
    .QueueDepth (QueueDepth)
  ) i_dut (
    .clk          (clk),
    .rstN         (rstN),
    .cfgWrite     (cfgWrite),
    .reqValid     (reqValid),
    .reqData      (reqData),
    .respReady    (respReady),
    .respValid    (respValid),
    .respData     (respData),
    .creditReturn (creditReturn)
  );

  always #20 clk = ~clk;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Same write rules as the hardware with locked entries and bases under a locked TOR frozen
  function automatic void modelWrite(cfgWriteT w);
    int   i;
    logic aboveTor;
    i = int'(w.idx);
    aboveTor = 1'b0;
    if (i + 1 < NumEntries) begin
      aboveTor = mCfg[i+1].lock && (mCfg[i+1].mode == Tor);
    end
    if (!mCfg[i].lock) begin
      if (w.cfgEn) begin
        mCfg[i] = w.cfg;
        mCfg[i].rsvd = 2'b00;
      end
      if (w.adrEn && !aboveTor) begin
        mAdr[i] = w.adr;
      end
    end
  endfunction

  // Scan entries from 0 upward so the first hit owns the access
  function automatic logic modelFault(accessReqT req);
    logic [XLen-1:0] word;
    logic [XLen-1:0] lo;
    logic            hit;
    logic            found;
    logic            anyOn;
    logic            perm;
    pmpCfgT          sel;
    int              ones;
    word = req.addr[PaBits-1:2];
    found = 1'b0;
    anyOn = 1'b0;
    sel = '0;
    for (int i = 0; i < NumEntries; i++) begin
      lo = '0;
      if (i > 0) begin
        lo = mAdr[i-1];
      end
      ones = 0;
      while (ones < XLen && mAdr[i][ones]) begin
        ones++;
      end
      case (mCfg[i].mode)
        Tor:     hit = (word >= lo) && (word < mAdr[i]);
        Na4:     hit = (word == mAdr[i]);
        // A region of 2^(ones+1) words where all-ones spans everything
        Napot:   hit = (ones >= XLen - 1) || ((word >> (ones + 1)) == (mAdr[i] >> (ones + 1)));
        default: hit = 1'b0;
      endcase
      if (hit && !found) begin
        found = 1'b1;
        sel = mCfg[i];
      end
      if (mCfg[i].mode != Off) begin
        anyOn = 1'b1;
      end
    end
    case (req.kind)
      Fetch:   perm = sel.x;
      Load:    perm = sel.r;
      default: perm = sel.w;
    endcase
    if (req.priv == MMode) begin
      return found && sel.lock && !perm;
    end
    return anyOn && !(found && perm);
  endfunction

  function automatic int creditsHeld();
    return QueueDepth - sentCnt + retCnt;
  endfunction

  task automatic checkValue(string name, logic [63:0] got, logic [63:0] want);
    checks++;
    if (got !== want) begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, want);
      errors++;
    end
  endtask

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic pmpCfgT makeCfg(logic lock, pmpModeT mode, logic x, logic w, logic r);
    pmpCfgT c;
    c = '0;
    c.lock = lock;
    c.mode = mode;
    c.x = x;
    c.w = w;
    c.r = r;
    return c;
  endfunction

  // Addresses cluster around word 0x100 so entries overlap and misses are common
  function automatic accessReqT makeReq(int privSel);
    accessReqT       r;
    logic [XLen-1:0] word;
    word = $urandom_range(32'h1a0, 32'hf0);
    r.addr = {word, 2'($urandom_range(3, 0))};
    r.kind = accessKindT'(2'($urandom_range(2, 0)));
    r.tag = '0;
    case (privSel)
      0:       r.priv = ($urandom_range(1, 0) != 0) ? SMode : UMode;
      1:       r.priv = MMode;
      default: r.priv = privModeT'(2'($urandom_range(3, 0)) | 2'($urandom_range(1, 0)));
    endcase
    if (r.priv == 2'd2) begin
      r.priv = UMode;
    end
    return r;
  endfunction

  task automatic writeEntry(int idx, pmpCfgT cfg, logic [XLen-1:0] adr, logic cfgEn,
                            logic adrEn);
    cfgWriteT w;
    w.cfgEn = cfgEn;
    w.adrEn = adrEn;
    w.idx = 4'(idx);
    w.cfg = cfg;
    w.adr = adr;
    @(posedge clk);
    cfgWrite <= w;
    modelWrite(w);
    @(posedge clk);
    cfgWrite <= '0;
  endtask

  task automatic randomEntry(int idx, logic allowLock);
    pmpCfgT          cfg;
    logic [XLen-1:0] adr;
    logic [XLen-1:0] base;
    int              k;
    // Random flags and reserved bits where the reserved ones must read back zero
    cfg = pmpCfgT'(8'($urandom));
    cfg.lock = allowLock && ($urandom_range(3, 0) == 0);
    base = $urandom_range(32'h190, 32'h100);
    k = $urandom_range(5, 0);
    case (cfg.mode)
      Tor:     adr = 32'h100 + 32'(idx * 24) + $urandom_range(23, 0);
      // k trailing ones over a zero give a 2^(k+1) word region
      Napot:   adr = (base & ~((32'd2 << k) - 1)) | ((32'd1 << k) - 1);
      default: adr = base;
    endcase
    writeEntry(idx, cfg, adr, 1'b1, 1'b1);
  endtask

  task automatic randomBank(logic allowLock);
    for (int i = 0; i < NumEntries; i++) begin
      randomEntry(i, allowLock);
    end
  endtask

  // Send requests only while a credit is held, then drain everything
  task automatic runTraffic(int count, int privSel, logic randReady);
    accessReqT r;
    int        sent;
    sent = 0;
    while (sent < count) begin
      @(posedge clk);
      respReady <= randReady ? 1'($urandom_range(1, 0)) : 1'b1;
      if (creditsHeld() > 0 && $urandom_range(3, 0) != 0) begin
        r = makeReq(privSel);
        r.tag = nextTag;
        nextTag = nextTag + 1'b1;
        reqValid <= 1'b1;
        reqData <= r;
        expQ.push_back(r);
        sentCnt++;
        sent++;
      end else begin
        reqValid <= 1'b0;
      end
    end
    @(posedge clk);
    reqValid <= 1'b0;
    respReady <= 1'b1;
    // The last credit returns no later than the last response is taken
    do begin
      @(negedge clk);
    end while (expQ.size() != 0);
    // Once idle every credit is back with the requester
    checkValue("credits", creditsHeld(), QueueDepth);
  endtask

  task automatic startTest();
    @(posedge clk);
    rstN <= 1'b0;
    reqValid <= 1'b0;
    cfgWrite <= '0;
    respReady <= 1'b1;
    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;
    expQ.delete();
    sentCnt = 0;
    for (int i = 0; i < NumEntries; i++) begin
      mCfg[i] = '0;
      mAdr[i] = '0;
    end
    testErrBase = errors;
  endtask

  task automatic endTest(string name);
    testsRun++;
    if (errors == testErrBase) begin
      $display("Test %0d %s: passed", testsRun, name);
    end else begin
      $display("Test %0d %s: %0d errors", testsRun, name, errors - testErrBase);
    end
  endtask

  //////////////////////////////
  // Response and credit monitor
  //////////////////////////////

  always @(posedge clk) begin
    if (!rstN) begin
      retCnt <= 0;
    end else begin
      if (creditReturn) begin
        if (retCnt >= sentCnt) begin
          $display("A credit came back with no request outstanding");
          errors++;
        end
        retCnt <= retCnt + 1;
      end
      if (respValid && respReady) begin
        if (expQ.size() == 0) begin
          $display("A response arrived with no request outstanding");
          errors++;
        end else begin
          expReq = expQ.pop_front();
          checkValue("respData.tag", respData.tag, expReq.tag);
          checkValue("respData.kind", respData.kind, expReq.kind);
          checkValue("respData.fault", respData.fault, modelFault(expReq));
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout after %0d cycles, %0d responses missing", cycles, expQ.size());
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    rstN <= 1'b0;
    cfgWrite <= '0;
    reqValid <= 1'b0;
    reqData <= '0;
    respReady <= 1'b1;
    nextTag = '0;
    void'($urandom(32'h21ad93d2));

    // With all entries Off nothing may fault in any mode
    startTest();
    runTraffic(AccPerTest, 2, 1'b0);
    endTest("reset state");

    startTest();
    randomBank(1'b0);
    runTraffic(AccPerTest, 0, 1'b0);
    endTest("matching modes");

    // Small read-only NA4 inside a wider write/exec NAPOT, then a read-only TOR
    startTest();
    writeEntry(0, makeCfg(1'b0, Na4, 1'b0, 1'b0, 1'b1), 32'h120, 1'b1, 1'b1);
    writeEntry(1, makeCfg(1'b0, Napot, 1'b1, 1'b1, 1'b0), 32'h11f, 1'b1, 1'b1);
    writeEntry(2, makeCfg(1'b0, Tor, 1'b0, 1'b0, 1'b1), 32'h180, 1'b1, 1'b1);
    for (int i = 3; i < NumEntries; i++) begin
      randomEntry(i, 1'b0);
    end
    runTraffic(AccPerTest, 0, 1'b0);
    endTest("priority");

    startTest();
    randomBank(1'b1);
    runTraffic(AccPerTest, 1, 1'b0);
    endTest("machine mode");

    // Lock a TOR entry, then try to open every entry and move every address
    startTest();
    writeEntry(5, makeCfg(1'b1, Tor, 1'b0, 1'b1, 1'b1), 32'h170, 1'b1, 1'b1);
    randomBank(1'b1);
    for (int i = 0; i < NumEntries; i++) begin
      writeEntry(i, makeCfg(1'b0, Napot, 1'b1, 1'b1, 1'b1), 32'h1ff, 1'b1, 1'b1);
    end
    for (int i = 0; i < NumEntries; i++) begin
      writeEntry(i, '0, $urandom_range(32'h1a0, 32'h100), 1'b0, 1'b1);
    end
    runTraffic(AccPerTest, 2, 1'b0);
    endTest("lock rules");

    startTest();
    randomBank(1'b0);
    runTraffic(AccPerTest, 2, 1'b1);
    endTest("flow control");

    $display("Tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
pmpPkg.sv
pmpAdrDec.sv
pmpRegFile.sv
pmpChecker.sv
accessQueue.sv
pmpGate.sv
pmpUnit.sv
tbPmpUnit.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tbPmpUnit -f all.f
out=$(./obj_dir/VtbPmpUnit)
echo "$out"
echo "$out" | grep -qx "Everything OK"
